//--- src/isaPkg.sv
package isaPkg;

  //////////////////////////////////////////////////
  // widths and memory

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int memoryWords = 256;
  localparam int memoryIndexWidth = $clog2(memoryWords);
  localparam string programFile = "program.hex";

  //////////////////////////////////////////////////
  // encodings

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    opR     = 7'b0110011,
    opImm   = 7'b0010011,
    opLoad  = 7'b0000011,
    opStore = 7'b0100011
  } opcodeT;

  // same codes as the classic ALU control output
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110,
    aluSlt = 4'b0111
  } aluOpT;

  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Word   = 3'b010; // lw / sw width

  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000; // sub

endpackage

//--- src/pipePkg.sv
package pipePkg;
  import isaPkg::*;

  //////////////////////////////////////////////////
  // pipeline barriers

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] instruction;
  } ifIdT;

  typedef struct packed {
    logic                     valid;
    logic [xlen-1:0]          lhsValue;
    logic [xlen-1:0]          rhsValue;
    logic [regIndexWidth-1:0] lhsIndex;
    logic [regIndexWidth-1:0] rhsIndex;
    logic [regIndexWidth-1:0] writeIndex;
    logic [xlen-1:0]          immediate;
    aluOpT                    aluOp;
    logic                     aluSrc;
    logic                     memRead;
    logic                     memWrite;
    logic                     regWrite;
  } idExT;

  typedef struct packed {
    logic                     valid;
    logic [xlen-1:0]          aluResult;
    logic [xlen-1:0]          storeData;
    logic [regIndexWidth-1:0] writeIndex;
    logic                     memRead;
    logic                     memWrite;
    logic                     regWrite;
  } exMemT;

  typedef struct packed {
    logic                     valid;
    logic [xlen-1:0]          memoryData;
    logic [xlen-1:0]          executionData;
    logic [regIndexWidth-1:0] writeIndex;
    logic                     memToReg;
    logic                     regWrite;
  } memWbT;

  //////////////////////////////////////////////////
  // side channels

  typedef struct packed {
    logic            request;
    logic            write;
    logic [xlen-1:0] address;
    logic [xlen-1:0] writeData;
  } memRequestT;

  typedef struct packed {
    logic                     valid;
    logic [regIndexWidth-1:0] index;
    logic [xlen-1:0]          data;
  } retireT;

  // forwarding source, also the register file write port
  typedef struct packed {
    logic                     regWrite;
    logic [regIndexWidth-1:0] index;
    logic [xlen-1:0]          data;
  } bypassT;

endpackage

//--- src/instructionFetch.sv
module instructionFetch
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic            fetchGrant,
  input  logic [xlen-1:0] readData,
  output memRequestT      fetchRequest,
  output ifIdT            ifId
);

  logic [xlen-1:0] pc;

  // fetch never stops asking, the arbiter decides
  always_comb begin
    fetchRequest.request   = 1'b1;
    fetchRequest.write     = 1'b0;
    fetchRequest.address   = pc;
    fetchRequest.writeData = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (fetchGrant) begin
      pc <= pc + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // IF/ID barrier

  always_ff @(posedge clk) begin
    if (reset) begin
      ifId.valid <= 1'b0;
    end else begin
      ifId.valid <= fetchGrant; // bubble when data side owns memory
    end
  end

  always_ff @(posedge clk) begin
    ifId.instruction <= readData;
  end

endmodule

//--- src/registerFile.sv
module registerFile
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [regIndexWidth-1:0] readIndex1,
  input  logic [regIndexWidth-1:0] readIndex2,
  input  bypassT                   write,
  output logic [xlen-1:0]          readData1,
  output logic [xlen-1:0]          readData2
);

  logic [xlen-1:0] registers [1:2**regIndexWidth-1]; // x0 is not stored

  function automatic logic [xlen-1:0] readPort(input logic [regIndexWidth-1:0] index,
                                               input bypassT port);
    if (index == '0) return '0;
    if (port.regWrite && port.index == index) return port.data; // write-through
    return registers[index];
  endfunction

  assign readData1 = readPort(readIndex1, write);
  assign readData2 = readPort(readIndex2, write);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 2**regIndexWidth; i++) begin
        registers[i] <= '0;
      end
    end else if (write.regWrite && write.index != '0) begin
      registers[write.index] <= write.data;
    end
  end

endmodule

//--- src/decodeStage.sv
module decodeStage
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  ifIdT                     ifId,
  output logic [regIndexWidth-1:0] readIndex1,
  output logic [regIndexWidth-1:0] readIndex2,
  input  logic [xlen-1:0]          readData1,
  input  logic [xlen-1:0]          readData2,
  output idExT                     idEx
);

  opcodeT          opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] immediate;
  aluOpT           aluSel;
  aluOpT           aluOp;
  logic            aluKnown;
  logic            aluSrc;
  logic            memRead;
  logic            memWrite;
  logic            regWrite;

  assign opcode     = opcodeT'(ifId.instruction[6:0]);
  assign funct3     = ifId.instruction[14:12];
  assign funct7     = ifId.instruction[31:25];
  assign readIndex1 = ifId.instruction[19:15];
  assign readIndex2 = ifId.instruction[24:20];

  //////////////////////////////////////////////////
  // ALU control from funct3 / funct7

  always_comb begin
    aluKnown = 1'b1;
    case (funct3)
      f3AddSub: aluSel = (opcode == opR && funct7 == f7Alt) ? aluSub : aluAdd;
      f3Slt:    aluSel = aluSlt;
      f3Or:     aluSel = aluOr;
      f3And:    aluSel = aluAnd;
      default: begin
        aluSel   = aluAdd;
        aluKnown = 1'b0;
      end
    endcase
    // funct7 only matters for R type, and only 0100000 with add/sub
    if (opcode == opR && !(funct7 == f7Base || (funct7 == f7Alt && funct3 == f3AddSub)))
      aluKnown = 1'b0;
  end

  //////////////////////////////////////////////////
  // main control and immediates

  always_comb begin
    immediate = '0;
    aluOp     = aluAdd;
    aluSrc    = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    regWrite  = 1'b0;
    case (opcode)
      opR: begin
        aluOp    = aluSel;
        regWrite = aluKnown;
      end
      opImm: begin
        immediate = {{20{ifId.instruction[31]}}, ifId.instruction[31:20]};
        aluOp     = aluSel;
        aluSrc    = 1'b1;
        regWrite  = aluKnown;
      end
      opLoad: begin
        immediate = {{20{ifId.instruction[31]}}, ifId.instruction[31:20]};
        aluSrc    = 1'b1;
        memRead   = (funct3 == f3Word);
        regWrite  = (funct3 == f3Word);
      end
      opStore: begin
        immediate = {{20{ifId.instruction[31]}}, ifId.instruction[31:25],
                     ifId.instruction[11:7]};
        aluSrc    = 1'b1;
        memWrite  = (funct3 == f3Word);
      end
      default: ; // unknown opcode leaves everything off
    endcase
  end

  // ID/EX barrier, a bubble or bad encoding clears control
  always_ff @(posedge clk) begin
    if (reset) begin
      idEx.valid    <= 1'b0;
      idEx.memRead  <= 1'b0;
      idEx.memWrite <= 1'b0;
      idEx.regWrite <= 1'b0;
      idEx.aluSrc   <= 1'b0;
    end else begin
      idEx.valid    <= ifId.valid && (regWrite || memWrite);
      idEx.memRead  <= ifId.valid && memRead;
      idEx.memWrite <= ifId.valid && memWrite;
      idEx.regWrite <= ifId.valid && regWrite;
      idEx.aluSrc   <= ifId.valid && aluSrc;
    end
  end

  always_ff @(posedge clk) begin
    idEx.lhsValue   <= readData1;
    idEx.rhsValue   <= readData2;
    idEx.lhsIndex   <= readIndex1;
    idEx.rhsIndex   <= readIndex2;
    idEx.writeIndex <= ifId.instruction[11:7];
    idEx.immediate  <= immediate;
    idEx.aluOp      <= aluOp;
  end

endmodule

//--- src/executeStage.sv
module executeStage
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  idExT   idEx,
  input  bypassT memBypass,
  input  bypassT wbBypass,
  output exMemT  exMem
);

  logic [xlen-1:0] lhsForwarded;
  logic [xlen-1:0] rhsForwarded;
  logic [xlen-1:0] lhsInput;
  logic [xlen-1:0] rhsInput;
  logic [xlen-1:0] aluResult;

  //////////////////////////////////////////////////
  // forwarding

  // newest producer wins, x0 is never forwarded
  function automatic logic [xlen-1:0] forward(input logic [regIndexWidth-1:0] index,
                                              input logic [xlen-1:0] regValue,
                                              input bypassT memSource,
                                              input bypassT wbSource);
    if (index != '0 && memSource.regWrite && memSource.index == index)
      return memSource.data;
    if (index != '0 && wbSource.regWrite && wbSource.index == index)
      return wbSource.data;
    return regValue;
  endfunction

  assign lhsForwarded = forward(idEx.lhsIndex, idEx.lhsValue, memBypass, wbBypass);
  assign rhsForwarded = forward(idEx.rhsIndex, idEx.rhsValue, memBypass, wbBypass);

  assign lhsInput = lhsForwarded;
  assign rhsInput = idEx.aluSrc ? idEx.immediate : rhsForwarded;

  //////////////////////////////////////////////////
  // ALU

  always_comb begin
    case (idEx.aluOp)
      aluAnd:  aluResult = lhsInput & rhsInput;
      aluOr:   aluResult = lhsInput | rhsInput;
      aluAdd:  aluResult = lhsInput + rhsInput;
      aluSub:  aluResult = lhsInput - rhsInput;
      aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(lhsInput) < $signed(rhsInput)};
      default: aluResult = lhsInput + rhsInput;
    endcase
  end

  // EX/MEM barrier
  always_ff @(posedge clk) begin
    if (reset) begin
      exMem.valid    <= 1'b0;
      exMem.memRead  <= 1'b0;
      exMem.memWrite <= 1'b0;
      exMem.regWrite <= 1'b0;
    end else begin
      exMem.valid    <= idEx.valid;
      exMem.memRead  <= idEx.memRead;
      exMem.memWrite <= idEx.memWrite;
      exMem.regWrite <= idEx.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    exMem.aluResult  <= aluResult;
    exMem.storeData  <= rhsForwarded; // sw data sees forwarding too
    exMem.writeIndex <= idEx.writeIndex;
  end

endmodule

//--- src/memoryArbiter.sv
module memoryArbiter
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic            clk,
  input  memRequestT      fetchRequest,
  input  memRequestT      dataRequest,
  output logic            fetchGrant,
  output logic [xlen-1:0] readData,
  output logic [xlen-1:0] dataReadData
);

  logic [xlen-1:0]             memoryArray [memoryWords];
  memRequestT                  granted;
  logic [memoryIndexWidth-1:0] wordIndex;
  logic [xlen-1:0]             readWord;

  initial begin
    $readmemh(programFile, memoryArray);
  end

  //////////////////////////////////////////////////
  // fixed priority, data side first

  assign fetchGrant = fetchRequest.request && !dataRequest.request;
  assign granted    = dataRequest.request ? dataRequest : fetchRequest;

  // byte address, word aligned
  assign wordIndex = granted.address[memoryIndexWidth+1:2];
  assign readWord  = memoryArray[wordIndex];

  // one access per cycle feeds both requesters
  assign readData     = readWord;
  assign dataReadData = readWord;

  always_ff @(posedge clk) begin
    if (granted.request && granted.write) begin
      memoryArray[wordIndex] <= granted.writeData;
    end
  end

endmodule

//--- src/memoryStage.sv
module memoryStage
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  exMemT           exMem,
  output memRequestT      dataRequest,
  input  logic [xlen-1:0] dataReadData,
  output bypassT          memBypass,
  output bypassT          wbBypass,
  output retireT          retire
);

  memWbT           memWb;
  logic [xlen-1:0] writebackData;

  always_comb begin
    dataRequest.request   = exMem.memRead || exMem.memWrite; // only lw / sw
    dataRequest.write     = exMem.memWrite;
    dataRequest.address   = exMem.aluResult;
    dataRequest.writeData = exMem.storeData;
  end

  //////////////////////////////////////////////////
  // MEM/WB barrier

  always_ff @(posedge clk) begin
    if (reset) begin
      memWb.valid    <= 1'b0;
      memWb.memToReg <= 1'b0;
      memWb.regWrite <= 1'b0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.memToReg <= exMem.memRead;
      memWb.regWrite <= exMem.regWrite;
    end
  end

  always_ff @(posedge clk) begin
    memWb.memoryData    <= dataReadData;
    memWb.executionData <= exMem.aluResult;
    memWb.writeIndex    <= exMem.writeIndex;
  end

  assign writebackData = memWb.memToReg ? memWb.memoryData : memWb.executionData;

  assign memBypass = '{regWrite: exMem.regWrite, index: exMem.writeIndex, data: exMem.aluResult};
  assign wbBypass  = '{regWrite: memWb.regWrite, index: memWb.writeIndex, data: writebackData};

  assign retire = '{valid: memWb.valid && memWb.regWrite, index: memWb.writeIndex,
                    data: writebackData};

endmodule

//--- src/CPU.sv
module CPU
  import isaPkg::*;
  import pipePkg::*;
(
  input  logic   clk,
  input  logic   reset,
  output retireT retire
);

  memRequestT               fetchRequest;
  memRequestT               dataRequest;
  logic                     fetchGrant;
  logic [xlen-1:0]          readData;
  logic [xlen-1:0]          dataReadData;
  ifIdT                     ifId;
  idExT                     idEx;
  exMemT                    exMem;
  bypassT                   memBypass;
  bypassT                   wbBypass;
  logic [regIndexWidth-1:0] readIndex1;
  logic [regIndexWidth-1:0] readIndex2;
  logic [xlen-1:0]          readData1;
  logic [xlen-1:0]          readData2;

  //////////////////////////////////////////////////
  // front end

  instructionFetch fetchUnit (
    .clk(clk), .reset(reset),
    .fetchGrant(fetchGrant), .readData(readData),
    .fetchRequest(fetchRequest), .ifId(ifId)
  );

  registerFile registers (
    .clk(clk), .reset(reset),
    .readIndex1(readIndex1), .readIndex2(readIndex2),
    .write(wbBypass), // writeback drives the write port
    .readData1(readData1), .readData2(readData2)
  );

  decodeStage decode (
    .clk(clk), .reset(reset), .ifId(ifId),
    .readIndex1(readIndex1), .readIndex2(readIndex2),
    .readData1(readData1), .readData2(readData2), .idEx(idEx)
  );

  //////////////////////////////////////////////////
  // back end and shared memory

  executeStage execute (
    .clk(clk), .reset(reset), .idEx(idEx),
    .memBypass(memBypass), .wbBypass(wbBypass), .exMem(exMem)
  );

  memoryStage memory (
    .clk(clk), .reset(reset), .exMem(exMem),
    .dataRequest(dataRequest), .dataReadData(dataReadData),
    .memBypass(memBypass), .wbBypass(wbBypass), .retire(retire)
  );

  memoryArbiter arbiter (
    .clk(clk),
    .fetchRequest(fetchRequest), .dataRequest(dataRequest),
    .fetchGrant(fetchGrant), .readData(readData), .dataReadData(dataReadData)
  );

endmodule

//--- verification/cpu_asserts.sv
module cpuAsserts
  import pipePkg::*;
(
  input logic       clk,
  input logic       reset,
  input retireT     retire,
  input logic       fetchGrant,
  input memRequestT dataRequest,
  input ifIdT       ifId
);

  int failureCount = 0; // read by the testbench when the run ends

  //////////////////////////////////////////////////
  // retire port

  // a cycle that follows a reset edge never retires
  quietInReset: assert property (@(posedge clk) $past(reset) |-> !retire.valid)
    else begin
      failureCount++;
      $error("retire.valid was high while reset was asserted");
    end

  knownIndex: assert property (@(posedge clk) disable iff (reset)
      retire.valid |-> !$isunknown(retire.index))
    else begin
      failureCount++;
      $error("retire.index is unknown on a valid retire");
    end

  //////////////////////////////////////////////////
  // arbiter

  // a data access denies fetch and the next IF/ID entry is a bubble
  dataFirst: assert property (@(posedge clk) disable iff (reset)
      dataRequest.request |-> !fetchGrant ##1 !ifId.valid)
    else begin
      failureCount++;
      $error("fetch was not held off with a bubble during a data access");
    end

endmodule

bind CPU cpuAsserts retireChecks (
  .clk(clk),
  .reset(reset),
  .retire(retire),
  .fetchGrant(fetchGrant),
  .dataRequest(dataRequest),
  .ifId(ifId)
);

//--- verification/cpuTb.sv
module cpuTb
  import isaPkg::*;
  import pipePkg::*;
();

  localparam int resetCycles = 16;
  localparam int halfPeriod = 10;

  logic   clk;
  logic   reset;
  retireT retire;

  logic [xlen-1:0]          modelMemory [memoryWords];
  logic [xlen-1:0]          modelRegs [32];
  logic [regIndexWidth-1:0] expectedIndex [$];
  logic [xlen-1:0]          expectedData [$];
  string                    expectedName [$];
  int programLength = 0;
  int retireCount = 0;
  int resetViolations = 0;
  int passCount = 0;
  int failCount = 0;
  int cycleCount = 0;
  int cycleLimit = 0;

  CPU uut (.clk(clk), .reset(reset), .retire(retire));

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  //////////////////////////////////////////////////
  // reference model

  function automatic logic [xlen-1:0] integerOp(input logic [2:0] funct3, input logic subtract,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    case (funct3)
      3'b000:  return subtract ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return '0;
    endcase
  endfunction

  function automatic string opName(input logic [2:0] funct3, input logic subtract);
    case (funct3)
      3'b000:  return subtract ? "sub" : "add";
      3'b010:  return "slt";
      3'b110:  return "or";
      3'b111:  return "and";
      default: return "";
    endcase
  endfunction

  // walks the program once in order, queueing each register write
  task automatic buildExpected();
    logic [xlen-1:0]          word;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [regIndexWidth-1:0] rd;
    logic [xlen-1:0]          lhs;
    logic [xlen-1:0]          rhs;
    logic [xlen-1:0]          address;
    logic [xlen-1:0]          result;
    string                    mnemonic;
    for (int i = 0; i < memoryWords; i++) begin
      word = modelMemory[memoryIndexWidth'(i)];
      if (word == '0) break; // end of program
      programLength++;
      opcode   = word[6:0];
      funct3   = word[14:12];
      rd       = word[11:7];
      lhs      = modelRegs[word[19:15]];
      rhs      = modelRegs[word[24:20]];
      result   = '0;
      mnemonic = "";
      case (opcode)
        7'b0110011: begin
          result   = integerOp(funct3, word[30], lhs, rhs);
          mnemonic = opName(funct3, word[30]);
        end
        7'b0010011: begin
          result   = integerOp(funct3, 1'b0, lhs, {{20{word[31]}}, word[31:20]});
          mnemonic = {opName(funct3, 1'b0), "i"};
        end
        7'b0000011: begin
          address  = lhs + {{20{word[31]}}, word[31:20]};
          result   = modelMemory[address[memoryIndexWidth+1:2]];
          mnemonic = "lw";
        end
        7'b0100011: begin
          address  = lhs + {{20{word[31]}}, word[31:25], word[11:7]};
          modelMemory[address[memoryIndexWidth+1:2]] = rhs;
          mnemonic = "sw";
        end
        default: mnemonic = "";
      endcase
      if (mnemonic.len() < 2) begin // empty, or a bare "i" from a bad funct3
        $display("model cannot decode word %h at index %0d", word, i);
        failCount++;
      end else if (mnemonic != "sw") begin
        expectedIndex.push_back(rd);
        expectedData.push_back(result);
        expectedName.push_back($sformatf("#%02d %s x%0d", i, mnemonic, rd));
        if (rd != '0) modelRegs[rd] = result;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // retire checking

  always @(negedge clk) begin
    if (reset) begin
      assert (!retire.valid) else begin
        $display("retire.valid went high while reset was asserted");
        resetViolations++;
      end
    end else if (retire.valid) begin
      assert (retireCount < expectedIndex.size()) begin
        assert (retire.index == expectedIndex[retireCount]
                && retire.data == expectedData[retireCount]) begin
          $display("[PASS] %s = %h", expectedName[retireCount], retire.data);
          passCount++;
        end else begin
          $display("[FAIL] %s: expected x%0d = %h, actual x%0d = %h",
                   expectedName[retireCount], expectedIndex[retireCount],
                   expectedData[retireCount], retire.index, retire.data);
          failCount++;
        end
      end else begin
        $display("unexpected retire of x%0d after the last write of the program", retire.index);
        failCount++;
      end
      retireCount++;
    end
  end

  initial begin
    reset = 1'b1;
    modelMemory = '{default: '0};
    modelRegs = '{default: '0};
    $readmemh("verification/program.hex", modelMemory);
    buildExpected();
    cycleLimit = resetCycles + 4 * programLength + 40;

    repeat (resetCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    reset <= 1'b0;
    assert (resetViolations == 0) begin
      $display("[PASS] reset: no retire during %0d reset cycles", resetCycles);
      passCount++;
    end else begin
      $display("reset check failed: %0d retires seen during reset", resetViolations);
      failCount++;
    end

    while (retireCount < expectedIndex.size() && cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    assert (retireCount >= expectedIndex.size()) begin
      repeat (4) @(posedge clk); // let a stray retire show up
      $display("[PASS] retire count = %0d", retireCount);
      passCount++;
    end else begin
      $display("timeout after %0d cycles with %0d of %0d expected retires seen",
               cycleCount, retireCount, expectedIndex.size());
      failCount++;
    end

    if (uut.retireChecks.failureCount != 0) begin
      $display("bound assertions failed %0d times", uut.retireChecks.failureCount);
      failCount++;
    end

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
src/isaPkg.sv
src/pipePkg.sv
src/instructionFetch.sv
src/registerFile.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryArbiter.sv
src/memoryStage.sv
src/CPU.sv
verification/cpu_asserts.sv
verification/cpuTb.sv

//--- run.sh
#!/bin/sh
# build the CPU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

# the unified memory loads program.hex from the working directory
cp verification/program.hex program.hex
if [ $? -ne 0 ]; then
  echo "could not copy verification/program.hex to the project root"
  exit 1
fi

verilator --binary --timing --assert --top-module cpuTb -f build.f -o cpuSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/cpuSim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1

//--- verification/program.hex
// one 32-bit instruction word per line, from byte address 0 upward
// a zero word ends the program, data lives at 0x200
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
001272B3 // and  x5, x4, x1
0022E333 // or   x6, x5, x2
001123B3 // slt  x7, x2, x1
0020A433 // slt  x8, x1, x2
20000493 // addi x9, x0, 512
0064A023 // sw   x6, 0(x9)
0034A223 // sw   x3, 4(x9)
0004A503 // lw   x10, 0(x9)
00700593 // addi x11, x0, 7
0044A603 // lw   x12, 4(x9)
FFF00693 // addi x13, x0, -1
00C50733 // add  x14, x10, x12
06300013 // addi x0, x0, 99
000007B3 // add  x15, x0, x0
40008833 // sub  x16, x1, x0
001008B3 // add  x17, x0, x1
00E88933 // add  x18, x17, x14
00000000 // end of program
